//--- logic/board_pkg.sv
package board_pkg;

	localparam int BOARD_SIZE = 8;
	localparam int CELLS = BOARD_SIZE * BOARD_SIZE;

	typedef logic [2:0] coord_t; // one axis position

	// x is the upper part of the flat index
	typedef struct packed
	{
		coord_t x;
		coord_t y;
	} cell_xy_t;

	// same cursor word seen two ways
	typedef union packed
	{
		logic [$clog2(CELLS)-1:0] idx; // board bit select
		cell_xy_t xy; // for moves
	} cell_u;

	// one bit per cell, set means a stone sits there
	typedef logic [CELLS-1:0] board_t;

	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
	} move_t;

endpackage

//--- logic/rules_pkg.sv
package rules_pkg;

	typedef logic player_t;
	localparam player_t PLAYER_ONE = 1'b0;
	localparam player_t PLAYER_TWO = 1'b1;

	typedef logic [1:0] life_t;
	localparam life_t LIVES_START = 2'd3;

	typedef logic [1:0] wins_t;
	localparam wins_t WINS_MAX = 2'd2; // saturation point

	// bcd seconds
	typedef struct packed
	{
		logic [3:0] tens;
		logic [3:0] ones;
	} digits_t;

	localparam digits_t RELOAD_FULL = '{tens: 4'd9, ones: 4'd9};
	localparam digits_t RELOAD_SHORT = '{tens: 4'd5, ones: 4'd9}; // player out of lives

	typedef struct packed
	{
		player_t player; // whose turn
		logic game_over;
		logic winner_valid;
		player_t winner;
		life_t lives_p1;
		life_t lives_p2;
		wins_t wins_p1;
		wins_t wins_p2;
	} status_t;

endpackage

//--- logic/turn_control.sv
module turn_control
(
	input  logic CLK_play,
	input  logic iRST_N,
	input  logic new_game,
	input  logic placed,
	input  logic expire,
	input  logic line_p1,
	input  logic line_p2,
	output logic new_game_q,
	output rules_pkg::status_t status,
	output logic turn_change
);

	logic line_p1_d;
	logic line_p2_d;
	logic rise_p1;
	logic rise_p2;
	logic charge;

	// a line stays up until the boards clear, so only the rise counts
	assign rise_p1 = line_p1 & ~line_p1_d;
	assign rise_p2 = line_p2 & ~line_p2_d;
	assign charge = expire & ~status.game_over;

	function automatic rules_pkg::wins_t add_win(input rules_pkg::wins_t w);
		return (w >= rules_pkg::WINS_MAX) ? w : w + 1'b1;
	endfunction

	function automatic rules_pkg::life_t take_life(input rules_pkg::life_t l);
		return (l == '0) ? l : l - 1'b1; // floor at zero
	endfunction

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			new_game_q <= 1'b0;
			turn_change <= 1'b0;
			line_p1_d <= 1'b0;
			line_p2_d <= 1'b0;
			status.player <= rules_pkg::PLAYER_ONE;
			status.game_over <= 1'b0;
			status.winner_valid <= 1'b0;
			status.winner <= rules_pkg::PLAYER_ONE;
			status.lives_p1 <= rules_pkg::LIVES_START;
			status.lives_p2 <= rules_pkg::LIVES_START;
			status.wins_p1 <= '0;
			status.wins_p2 <= '0;
		end
		else
		begin
			new_game_q <= new_game; // datapath clears a cycle later
			line_p1_d <= line_p1;
			line_p2_d <= line_p2;
			turn_change <= 1'b0;
			if (new_game)
			begin
				if (status.winner_valid)
				begin
					if (status.winner == rules_pkg::PLAYER_TWO)
						status.wins_p2 <= add_win(status.wins_p2);
					else
						status.wins_p1 <= add_win(status.wins_p1);
				end
				status.player <= rules_pkg::PLAYER_ONE;
				status.game_over <= 1'b0;
				status.winner_valid <= 1'b0;
				status.winner <= rules_pkg::PLAYER_ONE;
				status.lives_p1 <= rules_pkg::LIVES_START;
				status.lives_p2 <= rules_pkg::LIVES_START;
			end
			else
			begin
				if ((placed | charge) & ~status.game_over)
				begin
					status.player <= ~status.player;
					turn_change <= 1'b1; // lines up with the new player
				end
				if (charge)
				begin
					if (status.player == rules_pkg::PLAYER_TWO)
						status.lives_p2 <= take_life(status.lives_p2);
					else
						status.lives_p1 <= take_life(status.lives_p1);
				end
				if (!status.winner_valid && (rise_p1 || rise_p2))
				begin
					status.winner_valid <= 1'b1;
					status.game_over <= 1'b1;
					status.winner <= rise_p2 ? rules_pkg::PLAYER_TWO : rules_pkg::PLAYER_ONE;
				end
			end
		end
	end

endmodule

//--- logic/cursor_mover.sv
module cursor_mover
(
	input  logic CLK_play,
	input  logic iRST_N,
	input  board_pkg::move_t move,
	input  logic new_game_q,
	output board_pkg::cell_u cursor
);

	localparam board_pkg::coord_t EDGE = board_pkg::coord_t'(board_pkg::BOARD_SIZE - 1);

	function automatic board_pkg::coord_t fwd(input board_pkg::coord_t c);
		return (c == EDGE) ? '0 : c + 1'b1; // wrap to 0
	endfunction

	function automatic board_pkg::coord_t back(input board_pkg::coord_t c);
		return (c == '0) ? EDGE : c - 1'b1;
	endfunction

	// one step per cycle while a button is held
	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
			cursor <= '0;
		else if (new_game_q)
			cursor.idx <= '0;
		else if (move.up)
			cursor.xy.y <= fwd(cursor.xy.y);
		else if (move.down)
			cursor.xy.y <= back(cursor.xy.y);
		else if (move.left)
			cursor.xy.x <= back(cursor.xy.x);
		else if (move.right)
			cursor.xy.x <= fwd(cursor.xy.x);
	end

endmodule

//--- logic/board_store.sv
module board_store
(
	input  logic CLK_play,
	input  logic iRST_N,
	input  logic place,
	input  board_pkg::cell_u cursor,
	input  rules_pkg::player_t player,
	input  logic game_over,
	input  logic new_game_q,
	output board_pkg::board_t stones_p1,
	output board_pkg::board_t stones_p2,
	output logic placed
);

	logic empty;
	logic accept;

	assign empty = ~(stones_p1[cursor.idx] | stones_p2[cursor.idx]); // free on both boards
	assign accept = place & ~game_over & empty;

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			stones_p1 <= '0;
			stones_p2 <= '0;
			placed <= 1'b0;
		end
		else
		begin
			placed <= 1'b0;
			if (new_game_q)
			begin
				stones_p1 <= '0;
				stones_p2 <= '0;
			end
			else if (accept)
			begin
				placed <= 1'b1; // same cycle the stone shows
				if (player == rules_pkg::PLAYER_TWO)
					stones_p2[cursor.idx] <= 1'b1;
				else
					stones_p1[cursor.idx] <= 1'b1;
			end
			// taken cell, nothing happens and the turn stays
		end
	end

endmodule

//--- logic/line_detector.sv
module line_detector
#(
	parameter int RUN_LENGTH = 5
)
(
	input  logic CLK_play,
	input  logic iRST_N,
	input  board_pkg::board_t stones,
	output logic line
);

	localparam int N = board_pkg::BOARD_SIZE;
	localparam int LAST = N - RUN_LENGTH; // last start position of a run

	logic hit;

	////////////////////////////////////////////////////////////
	// every window of RUN_LENGTH cells in all four directions
	always_comb
	begin
		logic run_x;
		logic run_y;
		logic run_fall;
		logic run_rise;
		hit = 1'b0;
		for (int a = 0; a <= LAST; a++)
		begin
			for (int b = 0; b < N; b++)
			begin
				run_x = 1'b1;
				run_y = 1'b1;
				for (int k = 0; k < RUN_LENGTH; k++)
				begin
					run_x &= stones[(a + k) * N + b]; // along x, y fixed
					run_y &= stones[b * N + a + k]; // along y, x fixed
				end
				hit |= run_x | run_y;
			end
			for (int b = 0; b <= LAST; b++)
			begin
				run_fall = 1'b1;
				run_rise = 1'b1;
				for (int k = 0; k < RUN_LENGTH; k++)
				begin
					run_fall &= stones[(a + k) * N + b + k];
					run_rise &= stones[(a + k) * N + b + RUN_LENGTH - 1 - k];
				end
				hit |= run_fall | run_rise;
			end
		end
	end

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
			line <= 1'b0;
		else
			line <= hit;
	end

endmodule

//--- logic/turn_timer.sv
module turn_timer
#(
	parameter int STEP_CYCLES = 25_000_000
)
(
	input  logic CLK_play,
	input  logic iRST_N,
	input  logic reload,
	input  logic short_reload,
	input  logic hold,
	output rules_pkg::digits_t digits,
	output logic expire
);

	localparam int PW = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

	logic [PW-1:0] pre; // cycles into the current second
	logic step;
	rules_pkg::digits_t load_val;

	assign step = (pre == PW'(STEP_CYCLES - 1));
	assign load_val = short_reload ? rules_pkg::RELOAD_SHORT : rules_pkg::RELOAD_FULL;

	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			pre <= '0;
			digits <= rules_pkg::RELOAD_FULL;
			expire <= 1'b0;
		end
		else
		begin
			expire <= 1'b0;
			if (reload)
			begin
				pre <= '0; // full second from here
				digits <= load_val;
			end
			else if (!hold)
			begin
				if (!step)
					pre <= pre + 1'b1;
				else
				begin
					pre <= '0;
					if (digits == '0)
					begin
						expire <= 1'b1;
						digits <= load_val; // turn_change reload follows
					end
					else if (digits.ones == 4'd0)
					begin
						digits.ones <= 4'd9; // borrow
						digits.tens <= digits.tens - 1'b1;
					end
					else
						digits.ones <= digits.ones - 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/gomoku_top.sv
module gomoku_top
#(
	parameter int RUN_LENGTH = 5,
	parameter int STEP_CYCLES = 25_000_000
)
(
	input  logic CLK_play,
	input  logic iRST_N,
	input  board_pkg::move_t move,
	input  logic place,
	input  logic new_game,
	output board_pkg::board_t stones_p1,
	output board_pkg::board_t stones_p2,
	output board_pkg::cell_u cursor,
	output rules_pkg::digits_t digits,
	output rules_pkg::status_t status
);

	logic new_game_q;
	logic turn_change;
	logic placed;
	logic expire;
	logic line_p1;
	logic line_p2;
	logic reload;
	logic short_reload;

	////////////////////////////////////////////////////////////
	// timer control taken from the turn state
	assign reload = new_game_q | turn_change;
	assign short_reload = (status.player == rules_pkg::PLAYER_TWO) ?
		(status.lives_p2 == '0) : (status.lives_p1 == '0); // new player after the flip

	////////////////////////////////////////////////////////////
	turn_control i_turn_control
	(
		.CLK_play    (CLK_play),
		.iRST_N      (iRST_N),
		.new_game    (new_game),
		.placed      (placed),
		.expire      (expire),
		.line_p1     (line_p1),
		.line_p2     (line_p2),
		.new_game_q  (new_game_q),
		.status      (status),
		.turn_change (turn_change)
	);

	cursor_mover i_cursor_mover
	(
		.CLK_play   (CLK_play),
		.iRST_N     (iRST_N),
		.move       (move),
		.new_game_q (new_game_q),
		.cursor     (cursor)
	);

	board_store i_board_store
	(
		.CLK_play   (CLK_play),
		.iRST_N     (iRST_N),
		.place      (place),
		.cursor     (cursor),
		.player     (status.player),
		.game_over  (status.game_over),
		.new_game_q (new_game_q),
		.stones_p1  (stones_p1),
		.stones_p2  (stones_p2),
		.placed     (placed)
	);

	line_detector #(.RUN_LENGTH(RUN_LENGTH)) i_line_p1
	(
		.CLK_play (CLK_play),
		.iRST_N   (iRST_N),
		.stones   (stones_p1),
		.line     (line_p1)
	);

	line_detector #(.RUN_LENGTH(RUN_LENGTH)) i_line_p2
	(
		.CLK_play (CLK_play),
		.iRST_N   (iRST_N),
		.stones   (stones_p2),
		.line     (line_p2)
	);

	turn_timer #(.STEP_CYCLES(STEP_CYCLES)) i_turn_timer
	(
		.CLK_play     (CLK_play),
		.iRST_N       (iRST_N),
		.reload       (reload),
		.short_reload (short_reload),
		.hold         (status.game_over),
		.digits       (digits),
		.expire       (expire)
	);

endmodule

//--- verification/gomoku_assertions.sv
module gomoku_assertions
(
	input  logic CLK_play,
	input  logic iRST_N,
	input  board_pkg::board_t stones_p1,
	input  board_pkg::board_t stones_p2,
	input  logic place,
	input  logic placed,
	input  logic new_game,
	input  rules_pkg::status_t status
);

	////////////////////////////////////////////////////////////
	// a cell holds at most one stone
	no_overlap: assert property (@(posedge CLK_play) disable iff (!iRST_N)
		(stones_p1 & stones_p2) == '0)
		else $error("cell set on both boards");

	placed_after_place: assert property (@(posedge CLK_play) disable iff (!iRST_N)
		placed |-> $past(place))
		else $error("placed without a place strobe");

	// lives only refill on a new game
	lives_p1_no_rise: assert property (@(posedge CLK_play) disable iff (!iRST_N)
		!$past(new_game) |-> status.lives_p1 <= $past(status.lives_p1))
		else $error("player one lives rose");

	lives_p2_no_rise: assert property (@(posedge CLK_play) disable iff (!iRST_N)
		!$past(new_game) |-> status.lives_p2 <= $past(status.lives_p2))
		else $error("player two lives rose");

endmodule

bind gomoku_top gomoku_assertions i_gomoku_assertions
(
	.CLK_play  (CLK_play),
	.iRST_N    (iRST_N),
	.stones_p1 (stones_p1),
	.stones_p2 (stones_p2),
	.place     (place),
	.placed    (placed),
	.new_game  (new_game),
	.status    (status)
);

//--- verification/gomoku_tb.sv
module gomoku_tb;

	// one table row is a new game or a placement at x/y with the expected win
	typedef struct packed
	{
		logic ng;
		logic [2:0] x;
		logic [2:0] y;
		logic win;
	} row_t;

	localparam int STEP = 3; // cycles per timer second
	localparam int NROWS = 44;

	localparam row_t ROWS [NROWS] = '{
		'{1, 0, 0, 0},
		// player one along x with one try on a taken cell
		'{0, 0, 0, 0}, '{0, 0, 1, 0}, '{0, 0, 1, 0}, '{0, 1, 0, 0}, '{0, 1, 1, 0},
		'{0, 2, 0, 0}, '{0, 2, 1, 0}, '{0, 3, 0, 0}, '{0, 3, 1, 0}, '{0, 4, 0, 1},
		'{0, 5, 1, 0}, // ignored after the win
		'{1, 0, 0, 0},
		// player two along y
		'{0, 0, 0, 0}, '{0, 7, 0, 0}, '{0, 0, 1, 0}, '{0, 7, 1, 0}, '{0, 0, 2, 0},
		'{0, 7, 2, 0}, '{0, 0, 3, 0}, '{0, 7, 3, 0}, '{0, 6, 6, 0}, '{0, 7, 4, 1},
		'{1, 0, 0, 0},
		// player one on a falling diagonal
		'{0, 0, 0, 0}, '{0, 0, 7, 0}, '{0, 1, 1, 0}, '{0, 1, 7, 0}, '{0, 2, 2, 0},
		'{0, 2, 7, 0}, '{0, 3, 3, 0}, '{0, 3, 7, 0}, '{0, 4, 4, 1},
		'{1, 0, 0, 0},
		// player two on a rising diagonal
		'{0, 7, 7, 0}, '{0, 4, 0, 0}, '{0, 7, 6, 0}, '{0, 3, 1, 0}, '{0, 7, 5, 0},
		'{0, 2, 2, 0}, '{0, 7, 4, 0}, '{0, 1, 3, 0}, '{0, 6, 0, 0}, '{0, 0, 4, 1}
	};

	logic CLK_play = 1'b0;
	logic iRST_N;
	board_pkg::move_t move;
	logic place;
	logic new_game;
	board_pkg::board_t stones_p1;
	board_pkg::board_t stones_p2;
	board_pkg::cell_u cursor;
	rules_pkg::digits_t digits;
	rules_pkg::status_t status;

	// reference model
	board_pkg::board_t exp_p1;
	board_pkg::board_t exp_p2;
	board_pkg::cell_u exp_cur;
	rules_pkg::status_t exp_st;
	logic [7:0] lfsr;
	int errors;

	gomoku_top #(.RUN_LENGTH(5), .STEP_CYCLES(STEP)) i_gomoku_top
	(
		.CLK_play  (CLK_play),
		.iRST_N    (iRST_N),
		.move      (move),
		.place     (place),
		.new_game  (new_game),
		.stones_p1 (stones_p1),
		.stones_p2 (stones_p2),
		.cursor    (cursor),
		.digits    (digits),
		.status    (status)
	);

	always #5 CLK_play = ~CLK_play;

	////////////////////////////////////////////////////////////
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_cell(input string name, input board_pkg::cell_u got,
		input board_pkg::cell_u exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			stop_run("cursor position is wrong");
		end
	endtask

	task automatic check_board(input string name, input board_pkg::board_t got,
		input board_pkg::board_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run("board contents are wrong");
		end
	endtask

	task automatic check_digits(input string name, input rules_pkg::digits_t got,
		input rules_pkg::digits_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run("timer digits are wrong");
		end
	endtask

	task automatic check_status(input string name, input rules_pkg::status_t got,
		input rules_pkg::status_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			stop_run("game status is wrong");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			errors++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			stop_run("expiry came at the wrong cycle");
		end
	endtask

	////////////////////////////////////////////////////////////
	// taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr[0];
		lfsr = lfsr_next(lfsr);
	endtask

	// wrap rule where up beats down beats left beats right
	function automatic board_pkg::cell_u step_cursor(input board_pkg::cell_u c,
		input board_pkg::move_t m);
		board_pkg::cell_u n;
		n = c;
		if (m.up)
			n.xy.y = 3'((int'(c.xy.y) + 1) % 8);
		else if (m.down)
			n.xy.y = 3'((int'(c.xy.y) + 7) % 8);
		else if (m.left)
			n.xy.x = 3'((int'(c.xy.x) + 7) % 8);
		else if (m.right)
			n.xy.x = 3'((int'(c.xy.x) + 1) % 8);
		return n;
	endfunction

	function automatic rules_pkg::digits_t secs_to_digits(input int s);
		rules_pkg::digits_t d;
		d.tens = 4'(s / 10);
		d.ones = 4'(s % 10);
		return d;
	endfunction

	task automatic tick;
		@(negedge CLK_play);
	endtask

	task automatic push_move(input board_pkg::move_t m);
		move = m;
		tick;
		exp_cur = step_cursor(exp_cur, m);
		check_cell("cursor", cursor, exp_cur);
	endtask

	task automatic navigate(input logic [2:0] x, input logic [2:0] y);
		while (exp_cur.xy.x != x)
			push_move('{1'b0, 1'b0, 1'b0, 1'b1});
		while (exp_cur.xy.y != y)
			push_move('{1'b1, 1'b0, 1'b0, 1'b0});
		move = '0;
	endtask

	// round state after a new game with the pending win counted first
	task automatic clear_model;
		if (exp_st.winner_valid)
		begin
			if (exp_st.winner)
				exp_st.wins_p2 = (exp_st.wins_p2 >= 2) ? exp_st.wins_p2 : exp_st.wins_p2 + 1'b1;
			else
				exp_st.wins_p1 = (exp_st.wins_p1 >= 2) ? exp_st.wins_p1 : exp_st.wins_p1 + 1'b1;
		end
		exp_st.player = 1'b0;
		exp_st.game_over = 1'b0;
		exp_st.winner_valid = 1'b0;
		exp_st.winner = 1'b0;
		exp_st.lives_p1 = 2'd3;
		exp_st.lives_p2 = 2'd3;
		exp_p1 = '0;
		exp_p2 = '0;
		exp_cur = '0;
	endtask

	task automatic start_game;
		new_game = 1'b1;
		tick;
		new_game = 1'b0;
		tick; // boards, cursor and timer cleared by now
		clear_model();
		check_digits("digits", digits, secs_to_digits(99));
	endtask

	task automatic apply_row(input row_t r);
		logic accept;
		logic placer;
		if (r.ng)
			start_game();
		else
		begin
			navigate(r.x, r.y);
			accept = !exp_st.game_over && !(exp_p1[exp_cur.idx] | exp_p2[exp_cur.idx]);
			placer = exp_st.player;
			place = 1'b1;
			tick;
			place = 1'b0;
			tick;
			if (accept)
			begin
				if (placer)
					exp_p2[exp_cur.idx] = 1'b1;
				else
					exp_p1[exp_cur.idx] = 1'b1;
				exp_st.player = ~placer;
			end
			if (r.win)
			begin
				exp_st.winner_valid = 1'b1;
				exp_st.game_over = 1'b1;
				exp_st.winner = placer;
			end
		end
		tick; // winner latches two cycles after the stone
		check_cell("cursor", cursor, exp_cur);
		check_board("stones_p1", stones_p1, exp_p1);
		check_board("stones_p2", stones_p2, exp_p2);
		check_status("status", status, exp_st);
	endtask

	task automatic wait_flip(output int n);
		logic prev;
		prev = status.player;
		n = 0;
		while (status.player == prev)
		begin
			tick;
			n++;
			if (n > 2000)
				stop_run("timeout: the turn never passed on timer expiry");
		end
	endtask

	////////////////////////////////////////////////////////////
	initial
	begin
		board_pkg::move_t m;
		int n;
		int secs;
		errors = 0;
		lfsr = 8'd59;
		iRST_N = 1'b0;
		move = '0;
		place = 1'b0;
		new_game = 1'b0;
		exp_st = '0;
		clear_model();
		repeat (16) tick;
		iRST_N = 1'b1;
		check_status("status", status, exp_st);
		check_digits("digits", digits, secs_to_digits(99));

		// random walk from cell 0
		for (int i = 0; i < 40; i++)
		begin
			take_bit(m.up);
			take_bit(m.down);
			take_bit(m.left);
			take_bit(m.right);
			push_move(m);
		end
		move = '0;

		for (int pass = 0; pass < 2; pass++)
			foreach (ROWS[i])
				apply_row(ROWS[i]);

		// idle turns where every expiry costs the current player a life
		start_game();
		secs = 99;
		for (int i = 0; i < 7; i++)
		begin
			wait_flip(n);
			check_count("cycles to expiry", n, (secs + 1) * STEP + 1);
			if (exp_st.player)
				exp_st.lives_p2 = (exp_st.lives_p2 == 0) ? 2'd0 : exp_st.lives_p2 - 1'b1;
			else
				exp_st.lives_p1 = (exp_st.lives_p1 == 0) ? 2'd0 : exp_st.lives_p1 - 1'b1;
			exp_st.player = ~exp_st.player;
			check_status("status", status, exp_st);
			tick;
			if (exp_st.player)
				secs = (exp_st.lives_p2 == 0) ? 59 : 99;
			else
				secs = (exp_st.lives_p1 == 0) ? 59 : 99;
			check_digits("digits", digits, secs_to_digits(secs));
		end

		// a new game refills the lives spent above
		start_game();
		check_status("status", status, exp_st);

		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- all.f
logic/board_pkg.sv
logic/rules_pkg.sv
logic/turn_control.sv
logic/cursor_mover.sv
logic/board_store.sv
logic/line_detector.sv
logic/turn_timer.sv
logic/gomoku_top.sv
verification/gomoku_assertions.sv
verification/gomoku_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module gomoku_tb -o gomoku_sim

./obj_dir/gomoku_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
